//--- all.f
+incdir+hw
hw/core_types_pkg.sv
hw/lq_types_pkg.sv
hw/lq_entry.sv
hw/lq_alloc.sv
hw/lq_mem_arbiter.sv
hw/load_queue.sv
tb/load_queue_assertions.sv
tb/load_queue_tb.sv

//--- hw/core_types_pkg.sv
`default_nettype none

`include "lq_defs.svh"

package core_types_pkg;

	typedef logic [`XLEN-1:0]               xlen_t;     // Data word or address
	typedef logic [$clog2(`PRF_SIZE)-1:0]   prf_tag_t;  // Physical register tag
	typedef logic [$clog2(`ROB_SIZE):0]     rob_idx_t;  // ROB index plus wrap bit

	// Result broadcast from an execution unit
	typedef struct packed {
		logic     valid;
		prf_tag_t tag;
		xlen_t    data;
	} cdb_t;

	// Load handed over by rename
	typedef struct packed {
		logic     valid;
		xlen_t    base;
		xlen_t    offset;        // Low bits hold the tag while not ready
		logic     offset_ready;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
	} load_dispatch_t;

endpackage

`default_nettype wire

//--- hw/load_queue.sv
`timescale 1ns/1ns
`default_nettype none

`include "lq_defs.svh"

module load_queue
	import core_types_pkg::*, lq_types_pkg::*;
(
	input  wire                 clock,
	input  wire                 reset,
	input  wire                 clean,

	input  wire load_dispatch_t dispatch1,
	input  wire load_dispatch_t dispatch2,

	input  wire cdb_t           cdb1,
	input  wire cdb_t           cdb2,

	input  wire mem_resp_t      mem_resp,

	output mem_req_t            mem_req,
	output lq_complete_t        complete,
	output lq_count_t           free_slots
);

	lq_state_e           entry_state      [`LQ_SIZE];
	xlen_t               entry_addr       [`LQ_SIZE];
	rob_idx_t            entry_rob_idx    [`LQ_SIZE];
	prf_tag_t            entry_dest_tag   [`LQ_SIZE];
	xlen_t               entry_data       [`LQ_SIZE];
	load_dispatch_t      entry_write_data [`LQ_SIZE];
	logic [`LQ_SIZE-1:0] entry_free;
	logic [`LQ_SIZE-1:0] write;
	logic [`LQ_SIZE-1:0] write_sel2;
	logic [`LQ_SIZE-1:0] issue;
	logic [`LQ_SIZE-1:0] resp_hit;
	logic [`LQ_SIZE-1:0] retire;

	lq_alloc alloc_i (
		.entry_free      (entry_free),
		.dispatch1_valid (dispatch1.valid),
		.dispatch2_valid (dispatch2.valid),
		.write           (write),
		.write_sel2      (write_sel2),
		.free_slots      (free_slots)
	);

	for (genvar i = 0; i < `LQ_SIZE; i++) begin : g_entry
		assign entry_free[i]       = (entry_state[i] == IDLE);
		assign entry_write_data[i] = write_sel2[i] ? dispatch2 : dispatch1;  // Slot steering

		lq_entry entry_i (
			.clock      (clock),
			.reset      (reset),
			.clean      (clean),
			.write      (write[i]),
			.write_data (entry_write_data[i]),
			.cdb1       (cdb1),
			.cdb2       (cdb2),
			.issue      (issue[i]),
			.resp_hit   (resp_hit[i]),
			.retire     (retire[i]),
			.resp_data  (mem_resp.data),
			.state      (entry_state[i]),
			.addr       (entry_addr[i]),
			.rob_idx    (entry_rob_idx[i]),
			.dest_tag   (entry_dest_tag[i]),
			.data       (entry_data[i])
		);
	end

	lq_mem_arbiter arbiter_i (
		.entry_state    (entry_state),
		.entry_addr     (entry_addr),
		.entry_rob_idx  (entry_rob_idx),
		.entry_dest_tag (entry_dest_tag),
		.entry_data     (entry_data),
		.mem_resp       (mem_resp),
		.issue          (issue),
		.resp_hit       (resp_hit),
		.retire         (retire),
		.mem_req        (mem_req),
		.complete       (complete)
	);

endmodule

`default_nettype wire

//--- hw/lq_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "lq_defs.svh"

module lq_alloc
	import lq_types_pkg::*;
(
	input  wire  [`LQ_SIZE-1:0] entry_free,
	input  wire                 dispatch1_valid,
	input  wire                 dispatch2_valid,

	output logic [`LQ_SIZE-1:0] write,
	output logic [`LQ_SIZE-1:0] write_sel2,   // Entry takes the dispatch2 load
	output lq_count_t           free_slots
);

	lq_idx_t first_idx;
	lq_idx_t second_idx;
	logic    first_found;
	logic    second_found;

	// Lowest and second lowest free entries
	always_comb begin
		first_idx    = '0;
		second_idx   = '0;
		first_found  = 1'b0;
		second_found = 1'b0;
		for (int i = 0; i < `LQ_SIZE; i++) begin
			if (entry_free[i] && !first_found) begin
				first_idx   = lq_idx_t'(i);
				first_found = 1'b1;
			end else if (entry_free[i] && !second_found) begin
				second_idx   = lq_idx_t'(i);
				second_found = 1'b1;
			end
		end
	end

	always_comb begin
		free_slots = '0;
		for (int i = 0; i < `LQ_SIZE; i++) begin
			free_slots = free_slots + lq_count_t'(entry_free[i]);
		end
	end

	always_comb begin
		write      = '0;
		write_sel2 = '0;
		if (dispatch1_valid && dispatch2_valid) begin
			write[first_idx]       = first_found;
			if (second_found) begin
				write[second_idx]      = 1'b1;
				write_sel2[second_idx] = 1'b1;
			end
		end else if (dispatch1_valid) begin
			write[first_idx]       = first_found;
		end else if (dispatch2_valid) begin
			write[first_idx]       = first_found;  // Lone slot 2 load takes the lowest entry
			write_sel2[first_idx]  = first_found;
		end
	end

endmodule

`default_nettype wire

//--- hw/lq_defs.svh
`ifndef LQ_DEFS_SVH
`define LQ_DEFS_SVH

// Core data path width
`define XLEN 64

// Physical register file and reorder buffer sizes
`define PRF_SIZE 64
`define ROB_SIZE 32

// Load queue depth
`define LQ_SIZE 4

`endif

//--- hw/lq_entry.sv
`timescale 1ns/1ns
`default_nettype none

module lq_entry
	import core_types_pkg::*, lq_types_pkg::*;
(
	input  wire            clock,
	input  wire            reset,
	input  wire            clean,

	input  wire            write,
	input  wire load_dispatch_t write_data,

	input  wire cdb_t      cdb1,
	input  wire cdb_t      cdb2,

	input  wire            issue,
	input  wire            resp_hit,
	input  wire            retire,
	input  wire xlen_t     resp_data,

	output lq_state_e      state,
	output xlen_t          addr,
	output rob_idx_t       rob_idx,
	output prf_tag_t       dest_tag,
	output xlen_t          data
);

	lq_state_e state_next;
	xlen_t     base;
	xlen_t     offset;
	prf_tag_t  pending_tag;
	logic      cdb1_hit;
	logic      cdb2_hit;

	assign pending_tag = offset[$bits(prf_tag_t)-1:0];  // Only meaningful in WAIT_ADDR
	assign cdb1_hit    = cdb1.valid && (cdb1.tag == pending_tag);
	assign cdb2_hit    = cdb2.valid && (cdb2.tag == pending_tag);

	assign addr = base + offset;

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (write) begin
					state_next = write_data.offset_ready ? ISSUE : WAIT_ADDR;
				end
			end
			WAIT_ADDR: begin
				if (cdb1_hit || cdb2_hit) begin
					state_next = ISSUE;
				end
			end
			ISSUE: begin
				if (issue) begin
					state_next = WAIT_DATA;  // Request left this cycle
				end
			end
			WAIT_DATA: begin
				if (resp_hit) begin
					state_next = DONE;
				end
			end
			DONE: begin
				if (retire) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
		if (clean) begin
			state_next = IDLE;  // Flush wins over any other event
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Payload registers load as the state machine advances
	always_ff @(posedge clock) begin
		if (state == IDLE && write) begin
			base     <= write_data.base;
			offset   <= write_data.offset;
			rob_idx  <= write_data.rob_idx;
			dest_tag <= write_data.dest_tag;
		end else if (state == WAIT_ADDR && cdb1_hit) begin
			offset   <= cdb1.data;  // cdb1 taken first if both match
		end else if (state == WAIT_ADDR && cdb2_hit) begin
			offset   <= cdb2.data;
		end else if (state == WAIT_DATA && resp_hit) begin
			data     <= resp_data;
		end
	end

endmodule

`default_nettype wire

//--- hw/lq_mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

`include "lq_defs.svh"

module lq_mem_arbiter
	import core_types_pkg::*, lq_types_pkg::*;
(
	input  wire lq_state_e      entry_state    [`LQ_SIZE],
	input  wire xlen_t          entry_addr     [`LQ_SIZE],
	input  wire rob_idx_t       entry_rob_idx  [`LQ_SIZE],
	input  wire prf_tag_t       entry_dest_tag [`LQ_SIZE],
	input  wire xlen_t          entry_data     [`LQ_SIZE],
	input  wire mem_resp_t      mem_resp,

	output logic [`LQ_SIZE-1:0] issue,
	output logic [`LQ_SIZE-1:0] resp_hit,
	output logic [`LQ_SIZE-1:0] retire,
	output mem_req_t            mem_req,
	output lq_complete_t        complete
);

	logic [`LQ_SIZE-1:0] issue_req;
	logic [`LQ_SIZE-1:0] done_req;
	lq_idx_t             issue_idx;
	lq_idx_t             retire_idx;

	// Lowest index wins
	function automatic lq_idx_t lowest_set(input logic [`LQ_SIZE-1:0] req);
		lq_idx_t idx;
		idx = '0;
		for (int i = `LQ_SIZE-1; i >= 0; i--) begin
			if (req[i]) begin
				idx = lq_idx_t'(i);
			end
		end
		return idx;
	endfunction

	always_comb begin
		for (int i = 0; i < `LQ_SIZE; i++) begin
			issue_req[i] = (entry_state[i] == ISSUE);
			done_req[i]  = (entry_state[i] == DONE);
			resp_hit[i]  = mem_resp.valid && (mem_resp.idx == lq_idx_t'(i))
				&& (entry_state[i] == WAIT_DATA);  // Stale answers after a flush drop here
			issue[i]     = |issue_req && (issue_idx == lq_idx_t'(i));
			retire[i]    = |done_req && (retire_idx == lq_idx_t'(i));
		end
	end

	assign issue_idx  = lowest_set(issue_req);
	assign retire_idx = lowest_set(done_req);

	assign mem_req = '{valid: |issue_req, idx: issue_idx, addr: entry_addr[issue_idx]};

	assign complete = '{
		valid:    |done_req,
		idx:      retire_idx,
		rob_idx:  entry_rob_idx[retire_idx],
		dest_tag: entry_dest_tag[retire_idx],
		data:     entry_data[retire_idx]
	};

endmodule

`default_nettype wire

//--- hw/lq_types_pkg.sv
`default_nettype none

`include "lq_defs.svh"

package lq_types_pkg;

	import core_types_pkg::*;

	typedef logic [$clog2(`LQ_SIZE)-1:0]    lq_idx_t;    // Entry index
	typedef logic [$clog2(`LQ_SIZE+1)-1:0]  lq_count_t;  // 0 up to LQ_SIZE

	typedef struct packed {
		logic    valid;
		lq_idx_t idx;
		xlen_t   addr;
	} mem_req_t;

	typedef struct packed {
		logic    valid;
		lq_idx_t idx;      // Entry the answer belongs to
		xlen_t   data;
	} mem_resp_t;

	typedef struct packed {
		logic     valid;
		lq_idx_t  idx;
		rob_idx_t rob_idx;
		prf_tag_t dest_tag;
		xlen_t    data;
	} lq_complete_t;

	typedef enum logic [2:0] {IDLE, WAIT_ADDR, ISSUE, WAIT_DATA, DONE} lq_state_e;

endpackage

`default_nettype wire

//--- tb/load_queue_assertions.sv
`timescale 1ns/1ns
`default_nettype none

`include "lq_defs.svh"

module load_queue_assertions
	import core_types_pkg::*, lq_types_pkg::*;
(
	input  wire                 clock,
	input  wire                 reset,
	input  wire                 clean,
	input  wire load_dispatch_t dispatch1,
	input  wire load_dispatch_t dispatch2,
	input  wire mem_req_t       mem_req,
	input  wire lq_complete_t   complete,
	input  wire lq_count_t      free_slots,
	input  wire lq_state_e      entry_state [`LQ_SIZE]
);

	// Issuing entry then waits for its data
	req_targets_busy_entry: assert property (@(posedge clock) disable iff (reset)
		mem_req.valid && !clean |=> entry_state[$past(mem_req.idx)] == WAIT_DATA)
		else $error("entry named by mem_req did not move to WAIT_DATA");

	complete_targets_busy_entry: assert property (@(posedge clock) disable iff (reset)
		complete.valid |=> entry_state[$past(complete.idx)] == IDLE)
		else $error("entry named by complete did not return to IDLE");

	// Rename may only use the slots it was shown
	dispatch_within_free: assert property (@(posedge clock) disable iff (reset)
		dispatch1.valid + dispatch2.valid <= free_slots)
		else $error("more loads dispatched than free_slots allows");

	clean_frees_all: assert property (@(posedge clock) disable iff (reset)
		clean |=> free_slots == `LQ_SIZE)
		else $error("free_slots not full one cycle after clean");

endmodule

bind load_queue load_queue_assertions assertions_i (
	.clock       (clock),
	.reset       (reset),
	.clean       (clean),
	.dispatch1   (dispatch1),
	.dispatch2   (dispatch2),
	.mem_req     (mem_req),
	.complete    (complete),
	.free_slots  (free_slots),
	.entry_state (entry_state)
);

`default_nettype wire

//--- tb/load_queue_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lq_defs.svh"

module load_queue_tb
	import core_types_pkg::*, lq_types_pkg::*;
();

	localparam xlen_t MEM_KEY    = 64'h5a5a_0f0f_c3c3_9696;  // Memory returns addr XOR this
	localparam int    MAX_CYCLES = 2000;                    // Five tests at 400 cycles each
	localparam int    WAIT_LIMIT = 100;

	logic           clock;
	logic           reset;
	logic           clean;
	load_dispatch_t dispatch1;
	load_dispatch_t dispatch2;
	cdb_t           cdb1;
	cdb_t           cdb2;
	mem_resp_t      mem_resp;
	mem_req_t       mem_req;
	lq_complete_t   complete;
	lq_count_t      free_slots;

	integer seed = 39;
	int     cycle_count = 0;
	int     errors = 0;
	int     checks = 0;
	int     tests = 0;
	int     test_errors = 0;

	logic  pend_valid  [`LQ_SIZE];  // One outstanding request per entry
	int    pend_delay  [`LQ_SIZE];
	xlen_t pend_addr   [`LQ_SIZE];
	int    fixed_delay [`LQ_SIZE];  // Nonzero replaces the random delay
	logic  picked;
	logic  cpl_seen;

	mem_req_t     req_log   [$];
	lq_complete_t cpl_log   [$];
	lq_count_t    count_log [$];    // free_slots in the cycle after each completion
	lq_idx_t      resp_log  [$];

	xlen_t    exp_base [`LQ_SIZE];
	xlen_t    exp_addr [`LQ_SIZE];
	rob_idx_t exp_rob  [`LQ_SIZE];
	prf_tag_t exp_tag  [`LQ_SIZE];

	load_queue dut_i (
		.clock      (clock),
		.reset      (reset),
		.clean      (clean),
		.dispatch1  (dispatch1),
		.dispatch2  (dispatch2),
		.cdb1       (cdb1),
		.cdb2       (cdb2),
		.mem_resp   (mem_resp),
		.mem_req    (mem_req),
		.complete   (complete),
		.free_slots (free_slots)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout, run stopped after %0d cycles", MAX_CYCLES);
		$display("SIMULATION FAILED");
		$finish;
	end

	// Memory model and output monitor
	always @(negedge clock) begin
		mem_resp = '0;
		if (!reset) begin
			for (int i = 0; i < `LQ_SIZE; i++) begin
				if (pend_valid[i] && pend_delay[i] > 0) begin
					pend_delay[i]--;
				end
			end
			picked = 1'b0;
			for (int i = 0; i < `LQ_SIZE; i++) begin
				if (!picked && pend_valid[i] && pend_delay[i] == 0) begin
					mem_resp.valid = 1'b1;
					mem_resp.idx   = lq_idx_t'(i);
					mem_resp.data  = pend_addr[i] ^ MEM_KEY;
					pend_valid[i]  = 1'b0;
					picked         = 1'b1;
					resp_log.push_back(lq_idx_t'(i));
				end
			end
			if (mem_req.valid === 1'b1) begin
				pend_valid[mem_req.idx] = 1'b1;
				pend_addr[mem_req.idx]  = mem_req.addr;
				pend_delay[mem_req.idx] = (fixed_delay[mem_req.idx] != 0) ?
					fixed_delay[mem_req.idx] : 1 + ({$random(seed)} % 6);
				req_log.push_back(mem_req);
			end
			if (cpl_seen) begin
				count_log.push_back(free_slots);
			end
			cpl_seen = (complete.valid === 1'b1);
			if (cpl_seen) begin
				cpl_log.push_back(complete);
			end
		end
	end

	task automatic compare_req(input string name, input mem_req_t exp, input mem_req_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: mem_req expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_complete(input string name, input lq_complete_t exp,
		input lq_complete_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: complete expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic compare_count(input string name, input lq_count_t exp, input lq_count_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: free_slots expected %0d actual %0d", name, exp, act);
		end
	endtask

	task automatic check_true(input string name, input logic cond, input string what);
		checks++;
		if (!cond) begin
			errors++;
			$display("%s: %s", name, what);
		end
	endtask

	function automatic xlen_t random_word();
		return {$random(seed), $random(seed)};
	endfunction

	function automatic load_dispatch_t make_load(input xlen_t base, input xlen_t offset,
		input logic ready, input rob_idx_t rob, input prf_tag_t tag);
		load_dispatch_t d;
		d.valid        = 1'b1;
		d.base         = base;
		d.offset       = offset;
		d.offset_ready = ready;
		d.rob_idx      = rob;
		d.dest_tag     = tag;
		return d;
	endfunction

	function automatic mem_req_t request_for(input lq_idx_t idx);
		mem_req_t r;
		r.valid = 1'b1;
		r.idx   = idx;
		r.addr  = exp_addr[idx];  // Base plus offset
		return r;
	endfunction

	function automatic lq_complete_t completion_for(input lq_idx_t idx);
		lq_complete_t c;
		c.valid    = 1'b1;
		c.idx      = idx;
		c.rob_idx  = exp_rob[idx];
		c.dest_tag = exp_tag[idx];
		c.data     = exp_addr[idx] ^ MEM_KEY;
		return c;
	endfunction

	task automatic expect_load(input lq_idx_t idx, input load_dispatch_t d);
		exp_base[idx] = d.base;
		exp_addr[idx] = d.base + d.offset;
		exp_rob[idx]  = d.rob_idx;
		exp_tag[idx]  = d.dest_tag;
	endtask

	task automatic dispatch_pair(input load_dispatch_t d1, input load_dispatch_t d2);
		@(negedge clock);
		dispatch1 = d1;
		dispatch2 = d2;
		@(negedge clock);
		dispatch1 = '0;
		dispatch2 = '0;
	endtask

	task automatic broadcast(input logic on_cdb2, input prf_tag_t tag, input xlen_t data);
		cdb_t bus;
		bus.valid = 1'b1;
		bus.tag   = tag;
		bus.data  = data;
		@(negedge clock);
		if (on_cdb2) begin
			cdb2 = bus;
		end else begin
			cdb1 = bus;
		end
		@(negedge clock);
		cdb1 = '0;
		cdb2 = '0;
	endtask

	task automatic flush_queue();
		@(negedge clock);
		clean = 1'b1;
		@(negedge clock);
		clean = 1'b0;
	endtask

	task automatic await_request(input string name, input lq_idx_t idx);
		int n;
		n = 0;
		while (req_log.size() == 0 && n < WAIT_LIMIT) begin
			@(posedge clock);
			n++;
		end
		if (req_log.size() == 0) begin
			errors++;
			$display("%s: no memory request within %0d cycles", name, WAIT_LIMIT);
		end else begin
			compare_req(name, request_for(idx), req_log.pop_front());
		end
	endtask

	// Completions must come back in the order memory answered
	task automatic await_completions(input string name, input int count, input int free_base);
		int      n;
		lq_idx_t idx;
		for (int k = 1; k <= count; k++) begin
			n = 0;
			while (count_log.size() == 0 && n < WAIT_LIMIT) begin
				@(posedge clock);
				n++;
			end
			if (count_log.size() == 0) begin
				errors++;
				$display("%s: no completion within %0d cycles", name, WAIT_LIMIT);
				return;
			end
			if (resp_log.size() == 0) begin
				errors++;
				$display("%s: completion seen without a memory response", name);
				return;
			end
			idx = resp_log.pop_front();
			compare_complete(name, completion_for(idx), cpl_log.pop_front());
			compare_count(name, lq_count_t'(free_base + k), count_log.pop_front());
		end
	endtask

	task automatic start_test();
		req_log.delete();
		cpl_log.delete();
		count_log.delete();
		resp_log.delete();
		for (int i = 0; i < `LQ_SIZE; i++) begin
			fixed_delay[i] = 0;
		end
		test_errors = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %s done, %0d errors", name, errors - test_errors);
	endtask

	task automatic test_immediate_load();
		string          name = "immediate_load";
		load_dispatch_t d;
		start_test();
		d = make_load(random_word(), 64'h40, 1'b1, 6'd3, 6'd17);
		expect_load(0, d);
		dispatch_pair(d, '0);
		compare_req(name, request_for(0), mem_req);  // Request in the cycle after dispatch
		await_request(name, 0);
		await_completions(name, 1, `LQ_SIZE - 1);
		finish_test(name);
	endtask

	task automatic test_tag_wakeup();
		string          name = "tag_wakeup";
		load_dispatch_t d1;
		load_dispatch_t d2;
		xlen_t          data1;
		xlen_t          data2;
		start_test();
		data1 = random_word();
		data2 = random_word();
		d1 = make_load(random_word(), xlen_t'(6'd21), 1'b0, 6'd5, 6'd40);
		d2 = make_load(random_word(), xlen_t'(6'd22), 1'b0, 6'd6, 6'd41);
		expect_load(0, d1);
		expect_load(1, d2);
		exp_addr[0] = exp_base[0] + data1;  // Offset taken from the bus
		exp_addr[1] = exp_base[1] + data2;
		dispatch_pair(d1, d2);
		repeat (4) @(posedge clock);
		check_true(name, req_log.size() == 0, "memory request seen before any broadcast");
		broadcast(1'b0, 6'd21, data1);
		await_request(name, 0);
		repeat (3) @(posedge clock);
		check_true(name, req_log.size() == 0, "second load issued before its broadcast");
		broadcast(1'b1, 6'd22, data2);
		await_request(name, 1);
		await_completions(name, 2, `LQ_SIZE - 2);
		finish_test(name);
	endtask

	task automatic test_dual_dispatch();
		string          name = "dual_dispatch";
		load_dispatch_t d1;
		load_dispatch_t d2;
		start_test();
		fixed_delay[0] = 5;  // Entry 1 gets its answer first
		fixed_delay[1] = 1;
		d1 = make_load(random_word(), 64'h8, 1'b1, 6'd9, 6'd2);
		d2 = make_load(random_word(), 64'h10, 1'b1, 6'd10, 6'd3);
		expect_load(0, d1);
		expect_load(1, d2);
		dispatch_pair(d1, d2);
		await_request(name, 0);
		await_request(name, 1);
		await_completions(name, 2, `LQ_SIZE - 2);
		finish_test(name);
	endtask

	task automatic test_full_queue();
		string          name = "full_queue";
		load_dispatch_t d [`LQ_SIZE];
		start_test();
		for (int i = 0; i < `LQ_SIZE; i++) begin
			d[i] = make_load(random_word(), xlen_t'(8 * i), 1'b1, rob_idx_t'(12 + i),
				prf_tag_t'(30 + i));
			expect_load(lq_idx_t'(i), d[i]);
		end
		dispatch_pair(d[0], d[1]);
		dispatch_pair(d[2], d[3]);
		compare_count(name, 0, free_slots);
		for (int i = 0; i < `LQ_SIZE; i++) begin
			await_request(name, lq_idx_t'(i));
		end
		await_completions(name, `LQ_SIZE, 0);
		finish_test(name);
	endtask

	task automatic test_flush();
		string          name = "flush";
		load_dispatch_t d [3];
		start_test();
		for (int i = 0; i < `LQ_SIZE; i++) begin
			fixed_delay[i] = 6;  // Answers arrive only after the flush
		end
		for (int i = 0; i < 3; i++) begin
			d[i] = make_load(random_word(), xlen_t'(16 * i), 1'b1, rob_idx_t'(20 + i),
				prf_tag_t'(50 + i));
		end
		dispatch_pair(d[0], d[1]);
		dispatch_pair(d[2], '0);
		flush_queue();
		compare_count(name, `LQ_SIZE, free_slots);
		repeat (12) @(posedge clock);
		@(negedge clock);
		check_true(name, cpl_log.size() == 0, "a completion appeared after the flush");
		check_true(name, req_log.size() == 3 && resp_log.size() == 3,
			"the three loads were not all requested and answered");
		compare_count(name, `LQ_SIZE, free_slots);
		finish_test(name);
	endtask

	initial begin
		reset     = 1'b1;
		clean     = 1'b0;
		dispatch1 = '0;
		dispatch2 = '0;
		cdb1      = '0;
		cdb2      = '0;
		mem_resp  = '0;
		cpl_seen  = 1'b0;
		for (int i = 0; i < `LQ_SIZE; i++) begin
			pend_valid[i]  = 1'b0;
			pend_delay[i]  = 0;
			fixed_delay[i] = 0;
		end
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		compare_count("reset", `LQ_SIZE, free_slots);
		test_immediate_load();
		test_tag_wakeup();
		test_dual_dispatch();
		test_full_queue();
		test_flush();
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
